// ==== tb/mips_patterns.hex ====
// tag 0: instruction byte address, instruction word
// tag 1: expected store address, store data; tag 2: unused, overflow pulse count
0 00000000 3c017fff  // lui   $1, 0x7fff
0 00000004 3421ffff  // ori   $1, $1, 0xffff
0 00000008 ac010000  // sw    $1, 0x000($0)
0 0000000c 2002fffb  // addi  $2, $0, -5
0 00000010 2403000c  // addiu $3, $0, 12
0 00000014 00432020  // add   $4, $2, $3
0 00000018 ac040004  // sw    $4, 0x004($0)
0 0000001c 00632021  // addu  $4, $3, $3
0 00000020 ac040008  // sw    $4, 0x008($0)
0 00000024 00622022  // sub   $4, $3, $2
0 00000028 ac04000c  // sw    $4, 0x00c($0)
0 0000002c 00432023  // subu  $4, $2, $3
0 00000030 ac040010  // sw    $4, 0x010($0)
0 00000034 00432024  // and   $4, $2, $3
0 00000038 ac040014  // sw    $4, 0x014($0)
0 0000003c 00432025  // or    $4, $2, $3
0 00000040 ac040018  // sw    $4, 0x018($0)
0 00000044 00432027  // nor   $4, $2, $3
0 00000048 ac04001c  // sw    $4, 0x01c($0)
0 0000004c 00432026  // xor   $4, $2, $3
0 00000050 ac040020  // sw    $4, 0x020($0)
0 00000054 0043202a  // slt   $4, $2, $3
0 00000058 ac040024  // sw    $4, 0x024($0)
0 0000005c 0043202b  // sltu  $4, $2, $3
0 00000060 ac040028  // sw    $4, 0x028($0)
0 00000064 2844fffd  // slti  $4, $2, -3
0 00000068 ac04002c  // sw    $4, 0x02c($0)
0 0000006c 30448f0f  // andi  $4, $2, 0x8f0f
0 00000070 ac040030  // sw    $4, 0x030($0)
0 00000074 34648001  // ori   $4, $3, 0x8001
0 00000078 ac040034  // sw    $4, 0x034($0)
0 0000007c 38448000  // xori  $4, $2, 0x8000
0 00000080 ac040038  // sw    $4, 0x038($0)
0 00000084 ac020100  // sw    $2, 0x100($0)
0 00000088 8c050100  // lw    $5, 0x100($0)
0 0000008c ac050104  // sw    $5, 0x104($0)
0 00000090 10630001  // beq   $3, $3, +1 taken
0 00000094 ac030108  // sw    $3, 0x108($0) skipped
0 00000098 10430001  // beq   $2, $3, +1 not taken
0 0000009c ac03010c  // sw    $3, 0x10c($0)
0 000000a0 0c00002a  // jal   0x0a8
0 000000a4 ac030110  // sw    $3, 0x110($0) skipped
0 000000a8 ac1f0114  // sw    $31, 0x114($0)
0 000000ac 00213820  // add   $7, $1, $1 overflows
0 000000b0 00214021  // addu  $8, $1, $1
0 000000b4 3c098000  // lui   $9, 0x8000
0 000000b8 01215022  // sub   $10, $9, $1 overflows
0 000000bc 01215823  // subu  $11, $9, $1
0 000000c0 ac070118  // sw    $7, 0x118($0)
0 000000c4 ac0a011c  // sw    $10, 0x11c($0)
0 000000c8 202c0001  // addi  $12, $1, 1 overflows
0 000000cc 242d0001  // addiu $13, $1, 1
0 000000d0 ac0c0120  // sw    $12, 0x120($0)
0 000000d4 08000000  // j 0, dropped opcode
0 000000d8 1000ffff  // beq   $0, $0, -1 final loop
1 00000000 7fffffff
1 00000004 00000007
1 00000008 00000018
1 0000000c 00000011
1 00000010 ffffffef
1 00000014 00000008
1 00000018 ffffffff
1 0000001c 00000000
1 00000020 fffffff7
1 00000024 00000001
1 00000028 00000000
1 0000002c 00000001
1 00000030 00008f0b
1 00000034 0000800d
1 00000038 ffff7ffb
1 00000100 fffffffb
1 00000104 fffffffb
1 0000010c 0000000c
1 00000114 000000a4
1 00000118 fffffffe
1 0000011c 00000001
1 00000120 80000000
2 00000000 00000003

// ==== vlog.f ====
design/mips_isa_pkg.sv
design/mips_ctrl_pkg.sv
design/mips_ctrl_if.sv
design/mips_alu.sv
design/mips_branch_unit.sv
design/mips_regfile.sv
design/mips_control.sv
design/mips_datapath.sv
design/mips_core.sv
tb/mips_core_sva.sv
tb/mips_core_tb.sv

// ==== Makefile ====
# Verilator build and run for the multicycle MIPS core testbench

TOP       ?= mips_core_tb
SRC_LIST  ?= vlog.f
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(SRC_LIST)

run: compile
	$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "TEST PASSED" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/mips_core_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_core_tb
    import mips_isa_pkg::*;
();

    localparam int    clk_period   = 100;
    localparam int    reset_cycles = 10;
    localparam int    mem_words    = 1 << mem_index_bits;
    localparam int    char_nl      = 10;
    localparam int    char_slash   = 47;
    localparam int    char_zero    = 48;
    localparam string pattern_file = "tb/mips_patterns.hex";

    logic  clk = 1'b0;
    logic  rst;
    word_t imem_addr;
    word_t imem_rdata;
    word_t dmem_addr;
    word_t dmem_wdata;
    logic  dmem_wr;
    word_t dmem_rdata;
    logic  integer_overflow;

    word_t imem [0:mem_words-1];
    word_t dmem [0:mem_words-1];
    word_t exp_addr [$];
    word_t exp_data [$];
    word_t last_pc = '0;
    int    exp_ovf;
    int    prog_words;
    int    store_count;
    int    ovf_count;
    int    value_errors;
    int    other_errors;
    int    sva_errors;
    int    timeout_cycles;
    logic  loaded = 1'b0;

    mips_core mips_core_i (
        .clk              (clk),
        .rst              (rst),
        .imem_addr        (imem_addr),
        .imem_rdata       (imem_rdata),
        .dmem_addr        (dmem_addr),
        .dmem_wdata       (dmem_wdata),
        .dmem_wr          (dmem_wr),
        .dmem_rdata       (dmem_rdata),
        .integer_overflow (integer_overflow)
    );

    bind mips_core mips_core_sva sva_i (
        .clk              (clk),
        .rst              (rst),
        .imem_addr        (imem_addr),
        .dmem_addr        (dmem_addr),
        .dmem_wdata       (dmem_wdata),
        .dmem_wr          (dmem_wr),
        .integer_overflow (integer_overflow)
    );

    always #(clk_period / 2) clk = ~clk;

    // both memories are word arrays indexed by byte address
    assign imem_rdata = imem[imem_addr[mem_index_bits+1:2]];
    assign dmem_rdata = dmem[dmem_addr[mem_index_bits+1:2]];

    always @(posedge clk) begin
        if (dmem_wr) begin
            dmem[dmem_addr[mem_index_bits+1:2]] <= dmem_wdata;
        end
    end

    task automatic fill_memories();
        for (int i = 0; i < mem_words; i++) begin
            // unloaded words decode as a dropped opcode
            imem[i] = word_t'(32'hfc00_0000 | i);
            dmem[i] <= word_t'(32'hdada_0000 | i);
        end
    endtask

    task automatic load_patterns();
        int    fd;
        int    c;
        int    n;
        word_t addr;
        word_t data;
        fd = $fopen(pattern_file, "r");
        assert (fd != 0) else begin
            $display("cannot open pattern file %s", pattern_file);
            other_errors++;
        end
        if (fd != 0) begin
            c = $fgetc(fd);
            while (c != -1) begin
                if (c == char_slash) begin
                    while (c != -1 && c != char_nl) begin
                        c = $fgetc(fd);
                    end
                end else if (c >= char_zero && c <= char_zero + 2) begin
                    n = $fscanf(fd, "%h %h", addr, data);
                    assert (n == 2) else begin
                        $display("pattern record with tag %0d is incomplete", c - char_zero);
                        other_errors++;
                    end
                    case (c - char_zero)
                        0: begin
                            imem[addr[mem_index_bits+1:2]] = data;
                            prog_words++;
                            if (addr > last_pc) begin
                                last_pc = addr;
                            end
                        end
                        1: begin
                            exp_addr.push_back(addr);
                            exp_data.push_back(data);
                        end
                        default: exp_ovf = int'(data);
                    endcase
                end
                c = $fgetc(fd);
            end
            $fclose(fd);
        end
    endtask

    task automatic check_store(input word_t addr, input word_t data);
        assert (store_count < exp_addr.size()) else begin
            $display("unexpected store of %h to address %h after the last expected one",
                     data, addr);
            other_errors++;
        end
        if (store_count < exp_addr.size()) begin
            assert (addr == exp_addr[store_count]) else begin
                $display("[FAIL] store %0d address: expected %h, actual %h",
                         store_count, exp_addr[store_count], addr);
                value_errors++;
            end
            assert (data == exp_data[store_count]) else begin
                $display("[FAIL] store %0d data: expected %h, actual %h",
                         store_count, exp_data[store_count], data);
                value_errors++;
            end
        end
        store_count++;
    endtask

    // program ends in a branch to itself
    task automatic wait_for_final_loop();
        while ((store_count < exp_addr.size()) || (imem_addr != last_pc)) begin
            @(negedge clk);
        end
    endtask

    always @(negedge clk) begin
        if (!rst && dmem_wr) begin
            check_store(dmem_addr, dmem_wdata);
        end
        if (!rst && integer_overflow) begin
            ovf_count++;
        end
    end

    initial begin
        wait (loaded);
        timeout_cycles = prog_words * 5 + reset_cycles + 20;
        #(timeout_cycles * clk_period);
        $display("timeout, final loop not reached after %0d cycles", timeout_cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rst = 1'b1;
        fill_memories();
        load_patterns();
        loaded = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
        if (prog_words > 0) begin
            wait_for_final_loop();
        end
        // a few loop passes catch stray stores
        repeat (5) @(negedge clk);
        assert (store_count == exp_addr.size()) else begin
            $display("[FAIL] store count: expected %0d, actual %0d",
                     exp_addr.size(), store_count);
            value_errors++;
        end
        assert (ovf_count == exp_ovf) else begin
            $display("[FAIL] overflow pulse count: expected %0d, actual %0d",
                     exp_ovf, ovf_count);
            value_errors++;
        end
        sva_errors = mips_core_i.sva_i.fail_count;
        $display("errors: %0d value, %0d other, %0d assertion",
                 value_errors, other_errors, sva_errors);
        if (value_errors + other_errors + sva_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/mips_core_sva.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_core_sva
    import mips_isa_pkg::*;
(
    input wire logic  clk,
    input wire logic  rst,
    input wire word_t imem_addr,
    input wire word_t dmem_addr,
    input wire word_t dmem_wdata,
    input wire logic  dmem_wr,
    input wire logic  integer_overflow
);

    int fail_count = 0;

    // both strobes last a single cycle
    store_single: assert property (@(posedge clk) disable iff (rst) dmem_wr |=> !dmem_wr)
        else begin
            $error("dmem_wr high in two consecutive cycles");
            fail_count++;
        end

    overflow_single: assert property (@(posedge clk) disable iff (rst)
        integer_overflow |=> !integer_overflow)
        else begin
            $error("integer_overflow high in two consecutive cycles");
            fail_count++;
        end

    outputs_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown({imem_addr, dmem_addr, dmem_wdata, dmem_wr, integer_overflow}))
        else begin
            $error("core output carries an unknown value");
            fail_count++;
        end

    quiet_in_reset: assert property (@(posedge clk) rst |-> (!dmem_wr && !integer_overflow))
        else begin
            $error("store or overflow strobe active during reset");
            fail_count++;
        end

endmodule

`default_nettype wire

// ==== design/mips_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_core
    import mips_isa_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    output word_t imem_addr,
    input  word_t imem_rdata,
    output word_t dmem_addr,
    output word_t dmem_wdata,
    output logic  dmem_wr,
    input  word_t dmem_rdata,
    output logic  integer_overflow
);

    mips_ctrl_if cif ();

    mips_control control_i (
        .clk              (clk),
        .rst              (rst),
        .cif              (cif.ctrl),
        .integer_overflow (integer_overflow)
    );

    mips_datapath datapath_i (
        .clk        (clk),
        .rst        (rst),
        .cif        (cif.dp),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata)
    );

    // store strobe straight from the FSM
    assign dmem_wr = cif.dm_wr;

endmodule

`default_nettype wire

// ==== design/mips_datapath.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_datapath
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    mips_ctrl_if.dp cif,
    output word_t imem_addr,
    input  word_t imem_rdata,
    output word_t dmem_addr,
    output word_t dmem_wdata,
    input  word_t dmem_rdata
);

    word_t     pc;
    word_t     npc;
    word_t     imm_ext;
    word_t     rd_a;
    word_t     rd_b;
    word_t     opnd_a;
    word_t     opnd_b;
    word_t     alu_b;
    word_t     alu_res;
    word_t     alu_res_q;
    word_t     mdr;
    word_t     wb_data;
    reg_addr_t wb_addr;
    logic      alu_ovf;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc        <= '0;
            cif.instr <= '0;
            cif.alu_ovf <= 1'b0;
        end else begin
            if (cif.pc_wr) begin
                pc <= npc;
            end
            if (cif.ir_wr) begin
                cif.instr <= imem_rdata;
            end
            cif.alu_ovf <= alu_ovf;
        end
    end

    // operand, result and load data registers track every cycle
    always_ff @(posedge clk) begin
        opnd_a    <= rd_a;
        opnd_b    <= rd_b;
        alu_res_q <= alu_res;
        mdr       <= dmem_rdata;
    end

    assign alu_b = cif.alu_src_imm ? imm_ext : opnd_b;

    always_comb begin
        case (cif.dst_sel)
            dst_rt:   wb_addr = cif.instr.i_form.rt;
            dst_link: wb_addr = link_reg;
            default:  wb_addr = cif.instr.r_form.rd;
        endcase
    end

    always_comb begin
        case (cif.wb_sel)
            wb_mem:  wb_data = mdr;
            wb_pc:   wb_data = pc;
            wb_imm:  wb_data = imm_ext;
            default: wb_data = alu_res_q;
        endcase
    end

    mips_regfile regfile_i (
        .clk       (clk),
        .rst       (rst),
        .wr        (cif.rf_wr),
        .wr_addr   (wb_addr),
        .wr_data   (wb_data),
        .rd_addr_a (cif.instr.i_form.rs),
        .rd_data_a (rd_a),
        .rd_addr_b (cif.instr.i_form.rt),
        .rd_data_b (rd_b)
    );

    mips_alu alu_i (
        .op_a     (opnd_a),
        .op_b     (alu_b),
        .op       (cif.alu_op),
        .result   (alu_res),
        .zero     (cif.alu_zero),
        .overflow (alu_ovf)
    );

    mips_branch_unit branch_unit_i (
        .pc      (pc),
        .instr   (cif.instr),
        .ext_op  (cif.ext_op),
        .npc_op  (cif.npc_op),
        .imm_ext (imm_ext),
        .npc     (npc)
    );

    assign imem_addr  = pc;
    assign dmem_addr  = alu_res_q;
    assign dmem_wdata = opnd_b;

endmodule

`default_nettype wire

// ==== design/mips_control.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_control
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;
(
    input  logic clk,
    input  logic rst,
    mips_ctrl_if.ctrl cif,
    output logic integer_overflow
);

    state_t  state;
    state_t  state_next;
    opcode_t opcode;
    funct_t  funct;
    logic    r_valid;
    logic    is_r_alu;
    logic    is_i_alu;
    logic    is_logic_imm;
    logic    is_lui;
    logic    is_lw;
    logic    is_sw;
    logic    is_beq;
    logic    is_jal;
    logic    ovf_op;

    assign opcode = cif.instr.r_form.opcode;
    assign funct  = cif.instr.r_form.funct;

    // register forms need a zero shift amount
    assign r_valid  = (opcode == op_special) && (cif.instr.r_form.shamt == '0);
    assign is_r_alu = r_valid && (funct inside {fn_add, fn_addu, fn_sub, fn_subu, fn_slt,
                                                fn_sltu, fn_and, fn_or, fn_xor, fn_nor});
    assign is_i_alu = opcode inside {op_addi, op_addiu, op_slti, op_sltiu,
                                     op_andi, op_ori, op_xori};
    assign is_logic_imm = opcode inside {op_andi, op_ori, op_xori};
    assign is_lui = (opcode == op_lui) && (cif.instr.i_form.rs == '0);
    assign is_lw  = (opcode == op_lw);
    assign is_sw  = (opcode == op_sw);
    assign is_beq = (opcode == op_beq);
    assign is_jal = (opcode == op_jal);

    // signed forms that report overflow
    assign ovf_op = (r_valid && (funct == fn_add || funct == fn_sub)) || (opcode == op_addi);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= fetch;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        case (state)
            fetch:   state_next = decode;
            decode: begin
                if (is_r_alu || is_i_alu) begin
                    state_next = alu_exe;
                end else if (is_lui) begin
                    state_next = lui_wb;
                end else if (is_lw || is_sw) begin
                    state_next = dm_exe;
                end else if (is_beq) begin
                    state_next = beq_exe;
                end else if (is_jal) begin
                    state_next = jal_exe;
                end else begin
                    state_next = fetch;
                end
            end
            alu_exe: state_next = alu_wb;
            dm_exe:  state_next = is_sw ? dm_sw : dm_lw;
            dm_lw:   state_next = dm_wb;
            default: state_next = fetch;
        endcase
    end

    assign cif.ir_wr = (state == fetch);
    assign cif.pc_wr = (state == fetch) || (state == jal_exe) ||
                       ((state == beq_exe) && cif.alu_zero);
    assign cif.rf_wr = (state == alu_wb) || (state == lui_wb) ||
                       (state == dm_wb) || (state == jal_exe);
    assign cif.dm_wr = (state == dm_sw);

    // address calculation uses the immediate too
    assign cif.alu_src_imm = is_i_alu || is_lw || is_sw;

    assign cif.ext_op  = is_lui ? ext_upper : (is_logic_imm ? ext_zero : ext_sign);
    assign cif.dst_sel = is_jal ? dst_link : (is_r_alu ? dst_rd : dst_rt);
    assign cif.npc_op  = (state == jal_exe) ? npc_jump :
                         ((state == beq_exe) ? npc_branch : npc_seq);

    always_comb begin
        case (state)
            dm_wb:   cif.wb_sel = wb_mem;
            jal_exe: cif.wb_sel = wb_pc;
            lui_wb:  cif.wb_sel = wb_imm;
            default: cif.wb_sel = wb_alu;
        endcase
    end

    always_comb begin
        cif.alu_op = alu_add;
        if (is_beq) begin
            cif.alu_op = alu_sub;
        end else if (r_valid) begin
            case (funct)
                fn_sub, fn_subu: cif.alu_op = alu_sub;
                fn_slt:          cif.alu_op = alu_slt;
                fn_sltu:         cif.alu_op = alu_sltu;
                fn_and:          cif.alu_op = alu_and;
                fn_or:           cif.alu_op = alu_or;
                fn_nor:          cif.alu_op = alu_nor;
                fn_xor:          cif.alu_op = alu_xor;
                default:         cif.alu_op = alu_add;
            endcase
        end else begin
            case (opcode)
                op_slti:  cif.alu_op = alu_slt;
                op_sltiu: cif.alu_op = alu_sltu;
                op_andi:  cif.alu_op = alu_and;
                op_ori:   cif.alu_op = alu_or;
                op_xori:  cif.alu_op = alu_xor;
                default:  cif.alu_op = alu_add;
            endcase
        end
    end

    assign integer_overflow = (state == alu_wb) && ovf_op && cif.alu_ovf;

endmodule

`default_nettype wire

// ==== design/mips_regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_regfile
    import mips_isa_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      wr,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data,
    input  reg_addr_t rd_addr_a,
    output word_t     rd_data_a,
    input  reg_addr_t rd_addr_b,
    output word_t     rd_data_b
);

    word_t regs [0:(1 << reg_bits) - 1];

    // register 0 never written, stays zero
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < (1 << reg_bits); i++) begin
                regs[i] <= '0;
            end
        end else if (wr && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

endmodule

`default_nettype wire

// ==== design/mips_branch_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_branch_unit
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;
(
    input  word_t   pc,
    input  instr_u  instr,
    input  ext_op_t ext_op,
    input  npc_op_t npc_op,
    output word_t   imm_ext,
    output word_t   npc
);

    logic [imm_bits-1:0] imm;
    word_t               imm_sign;

    assign imm      = instr.i_form.imm;
    assign imm_sign = {{(word_bits - imm_bits){imm[imm_bits-1]}}, imm};

    always_comb begin
        case (ext_op)
            ext_zero:  imm_ext = {{(word_bits - imm_bits){1'b0}}, imm};
            ext_upper: imm_ext = {imm, {(word_bits - imm_bits){1'b0}}};
            default:   imm_ext = imm_sign;
        endcase
    end

    // pc already points past the branch here
    always_comb begin
        case (npc_op)
            npc_branch: npc = pc + (imm_sign << 2);
            npc_jump:   npc = {pc[31:28], instr.i_form.rs, instr.i_form.rt, imm, 2'b00};
            default:    npc = pc + 32'd4;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/mips_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_alu
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;
(
    input  word_t   op_a,
    input  word_t   op_b,
    input  alu_op_t op,
    output word_t   result,
    output logic    zero,
    output logic    overflow
);

    word_t sum;
    word_t diff;

    assign sum  = op_a + op_b;
    assign diff = op_a - op_b;

    always_comb begin
        case (op)
            alu_add:  result = sum;
            alu_sub:  result = diff;
            alu_or:   result = op_a | op_b;
            alu_slt:  result = word_t'($signed(op_a) < $signed(op_b));
            alu_sltu: result = word_t'(op_a < op_b);
            alu_and:  result = op_a & op_b;
            alu_nor:  result = ~(op_a | op_b);
            default:  result = op_a ^ op_b;
        endcase
    end

    // sign of result disagrees with operands of matching sign
    always_comb begin
        case (op)
            alu_add: overflow = (op_a[31] == op_b[31]) && (sum[31] != op_a[31]);
            alu_sub: overflow = (op_a[31] != op_b[31]) && (diff[31] != op_a[31]);
            default: overflow = 1'b0;
        endcase
    end

    assign zero = (op_a == op_b);

endmodule

`default_nettype wire

// ==== design/mips_ctrl_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface mips_ctrl_if
    import mips_isa_pkg::*, mips_ctrl_pkg::*;
();

    // strobes and selects from the control unit
    logic     ir_wr;
    logic     pc_wr;
    logic     rf_wr;
    logic     dm_wr;
    logic     alu_src_imm;
    alu_op_t  alu_op;
    ext_op_t  ext_op;
    npc_op_t  npc_op;
    wb_sel_t  wb_sel;
    dst_sel_t dst_sel;

    // status back from the datapath
    instr_u   instr;
    logic     alu_zero;
    logic     alu_ovf;

    modport ctrl (
        output ir_wr, pc_wr, rf_wr, dm_wr, alu_src_imm,
        output alu_op, ext_op, npc_op, wb_sel, dst_sel,
        input  instr, alu_zero, alu_ovf
    );

    modport dp (
        input  ir_wr, pc_wr, rf_wr, dm_wr, alu_src_imm,
        input  alu_op, ext_op, npc_op, wb_sel, dst_sel,
        output instr, alu_zero, alu_ovf
    );

endinterface

`default_nettype wire

// ==== design/mips_ctrl_pkg.sv ====
`default_nettype none

package mips_ctrl_pkg;

    typedef enum logic [3:0] {
        fetch   = 4'd0,
        decode  = 4'd1,
        alu_exe = 4'd2,
        alu_wb  = 4'd3,
        dm_exe  = 4'd4,
        dm_sw   = 4'd5,
        dm_lw   = 4'd6,
        dm_wb   = 4'd7,
        beq_exe = 4'd8,
        jal_exe = 4'd9,
        lui_wb  = 4'd10
    } state_t;

    typedef enum logic [2:0] {
        alu_add  = 3'd0,
        alu_sub  = 3'd1,
        alu_or   = 3'd2,
        alu_slt  = 3'd3,
        alu_sltu = 3'd4,
        alu_and  = 3'd5,
        alu_nor  = 3'd6,
        alu_xor  = 3'd7
    } alu_op_t;

    // register file write data source
    typedef enum logic [1:0] {
        wb_alu = 2'd0,
        wb_mem = 2'd1,
        wb_pc  = 2'd2,
        wb_imm = 2'd3
    } wb_sel_t;

    typedef enum logic [1:0] {
        dst_rd   = 2'd0,
        dst_rt   = 2'd1,
        dst_link = 2'd2
    } dst_sel_t;

    typedef enum logic [1:0] {
        ext_zero  = 2'd0,
        ext_sign  = 2'd1,
        ext_upper = 2'd2
    } ext_op_t;

    typedef enum logic [1:0] {
        npc_seq    = 2'd0,
        npc_branch = 2'd1,
        npc_jump   = 2'd2
    } npc_op_t;

endpackage

`default_nettype wire

// ==== design/mips_isa_pkg.sv ====
`default_nettype none

package mips_isa_pkg;

    localparam int word_bits  = 32;
    localparam int op_bits    = 6;
    localparam int reg_bits   = 5;
    localparam int shamt_bits = 5;
    localparam int funct_bits = 6;
    localparam int imm_bits   = 16;

    // word index width of each external memory
    localparam int mem_index_bits = 10;

    typedef logic [word_bits-1:0]  word_t;
    typedef logic [reg_bits-1:0]   reg_addr_t;
    typedef logic [op_bits-1:0]    opcode_t;
    typedef logic [funct_bits-1:0] funct_t;

    typedef struct packed {
        opcode_t               opcode;
        reg_addr_t             rs;
        reg_addr_t             rt;
        reg_addr_t             rd;
        logic [shamt_bits-1:0] shamt;
        funct_t                funct;
    } r_form_t;

    // jal target is {rs, rt, imm} of this view
    typedef struct packed {
        opcode_t             opcode;
        reg_addr_t           rs;
        reg_addr_t           rt;
        logic [imm_bits-1:0] imm;
    } i_form_t;

    typedef union packed {
        r_form_t r_form;
        i_form_t i_form;
    } instr_u;

    localparam opcode_t op_special = 6'h00;
    localparam opcode_t op_jal     = 6'h03;
    localparam opcode_t op_beq     = 6'h04;
    localparam opcode_t op_addi    = 6'h08;
    localparam opcode_t op_addiu   = 6'h09;
    localparam opcode_t op_slti    = 6'h0a;
    localparam opcode_t op_sltiu   = 6'h0b;
    localparam opcode_t op_andi    = 6'h0c;
    localparam opcode_t op_ori     = 6'h0d;
    localparam opcode_t op_xori    = 6'h0e;
    localparam opcode_t op_lui     = 6'h0f;
    localparam opcode_t op_lw      = 6'h23;
    localparam opcode_t op_sw      = 6'h2b;

    localparam funct_t fn_add  = 6'h20;
    localparam funct_t fn_addu = 6'h21;
    localparam funct_t fn_sub  = 6'h22;
    localparam funct_t fn_subu = 6'h23;
    localparam funct_t fn_and  = 6'h24;
    localparam funct_t fn_or   = 6'h25;
    localparam funct_t fn_xor  = 6'h26;
    localparam funct_t fn_nor  = 6'h27;
    localparam funct_t fn_slt  = 6'h2a;
    localparam funct_t fn_sltu = 6'h2b;

    localparam reg_addr_t link_reg = 5'd31;

endpackage

`default_nettype wire
